// ==== arcade_shell.f ====
hw/dl_pkg.sv
hw/video_pkg.sv
hw/download_sequencer.sv
hw/rom_store.sv
hw/color_expand.sv
hw/scanline_dim.sv
hw/arcade_shell.sv
test/arcade_shell_tb.sv

// ==== Bender.yml ====
package:
  name: arcade_shell

sources:
  # Packages first, then the RTL from the leaves up to the top level.
  - files:
      - hw/dl_pkg.sv
      - hw/video_pkg.sv
      - hw/download_sequencer.sv
      - hw/rom_store.sv
      - hw/color_expand.sv
      - hw/scanline_dim.sv
      - hw/arcade_shell.sv

  - target: test
    files:
      - test/arcade_shell_tb.sv

// ==== test/arcade_shell_tb.sv ====
`timescale 1ns/1ps

module arcade_shell_tb;
	import dl_pkg::*;
	import video_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int N_WRITES = 64;
	localparam int WR_HIGH = 3;
	localparam int WR_LOW = 2;
	localparam int N_PIXELS = 200;
	localparam int N_LINES = 6;
	localparam int LINE_LEN = 12;
	// The sum of the test lengths in cycles, doubled for margin.
	localparam int WATCHDOG_CYCLES = 2 * (100 + (N_WRITES + 20) * (WR_HIGH + WR_LOW + 1)
		+ 2 * (N_WRITES + 12) * 3 + N_PIXELS + 4 * (N_LINES * LINE_LEN + 6));

	logic                  clk_48 = 1'b0;
	logic                  reset;
	logic                  ioctl_download;
	logic                  ioctl_wr;
	logic [ROM_ADDR_W-1:0] ioctl_addr;
	logic [7:0]            ioctl_dout;
	logic                  status_reset;
	logic                  button_reset;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic [7:0]            rom_data;
	raw_pixel_t            pixel_in;
	scan_level_t           scanlines;
	out_pixel_t            pixel_out;
	logic                  core_reset;
	logic                  rom_loaded;

	logic [15:0]           lfsr = 16'd85;
	int                    checks = 0;
	int                    errors = 0;
	logic [7:0]            rom_model [1 << ROM_ADDR_W];
	logic [ROM_ADDR_W-1:0] written [$];
	raw_pixel_t            stim_q [$];
	out_pixel_t            exp_q [$];
	bit                    chk_q [$];

	arcade_shell i_dut (.*);

	always #(CLK_PERIOD / 2) clk_48 = ~clk_48;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// Repeating a 3-bit pattern twice is the same as multiplying by 9.
	function automatic logic [5:0] widen3(input logic [2:0] c);
		return 6'(c * 9);
	endfunction

	function automatic logic [5:0] dim(input logic [5:0] c, input scan_level_t level);
		int v;
		v = c;
		case (level)
			SCAN_DIM25: v = v - v / 4;
			SCAN_DIM50: v = v / 2;
			SCAN_DIM75: v = v / 4;
			default:    v = c;
		endcase
		return 6'(v);
	endfunction

	function automatic out_pixel_t expect_pixel(input raw_pixel_t p, input scan_level_t level,
		input logic odd);
		out_pixel_t o;
		logic       blank;
		blank = p.hblank | p.vblank;
		o.r = blank ? 6'd0 : widen3(p.r);
		o.g = blank ? 6'd0 : widen3(p.g);
		o.b = blank ? 6'd0 : widen3({p.b[1], p.b});
		if (odd) begin
			o.r = dim(o.r, level);
			o.g = dim(o.g, level);
			o.b = dim(o.b, level);
		end
		o.hs = p.hs;
		o.vs = p.vs;
		return o;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic write_byte(input logic [ROM_ADDR_W-1:0] addr, input logic [7:0] data);
		@(posedge clk_48);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		repeat (WR_HIGH) @(posedge clk_48);
		ioctl_wr <= 1'b0;
		repeat (WR_LOW) @(posedge clk_48);
	endtask

	task automatic read_check(input logic [ROM_ADDR_W-1:0] addr);
		@(posedge clk_48);
		rom_addr <= addr;
		@(posedge clk_48);
		@(negedge clk_48);
		check_value("rom_data", rom_data, rom_model[addr]);
	endtask

	task automatic download_random(input int n, input logic loaded_exp);
		logic [ROM_ADDR_W-1:0] a;
		logic [7:0]            d;
		for (int i = 0; i < n; i++) begin
			a = ROM_ADDR_W'(take_bits(ROM_ADDR_W));
			d = 8'(take_bits(8));
			write_byte(a, d);
			rom_model[a] = d;
			written.push_back(a);
			@(negedge clk_48);
			check_value("rom_loaded", rom_loaded, loaded_exp);
		end
	endtask

	// The output of pixel j shows up two edges after it is driven.
	task automatic stream_video(input scan_level_t level);
		int n;
		n = stim_q.size();
		for (int j = 0; j < n + 2; j++) begin
			@(posedge clk_48);
			scanlines <= level;
			if (j < n) begin
				pixel_in <= stim_q[j];
			end
			@(negedge clk_48);
			if (j >= 2 && chk_q[j-2]) begin
				check_value("pixel_out", pixel_out, exp_q[j-2]);
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic gate_reset_on_download();
		@(posedge clk_48);
		ioctl_download <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			download_random(1, 1'b0);
			check_value("core_reset", core_reset, 1);
		end
		@(posedge clk_48);
		ioctl_download <= 1'b0;
		@(posedge clk_48);
		@(negedge clk_48);
		check_value("rom_loaded", rom_loaded, 1);
		check_value("core_reset", core_reset, 1);
		@(posedge clk_48);
		@(negedge clk_48);
		check_value("rom_loaded", rom_loaded, 1);
		check_value("core_reset", core_reset, 0);
	endtask

	task automatic load_and_read_back();
		@(posedge clk_48);
		ioctl_download <= 1'b1;
		download_random(N_WRITES, 1'b1);
		@(posedge clk_48);
		ioctl_download <= 1'b0;
		foreach (written[i]) begin
			read_check(written[i]);
			read_check({written[i][ROM_ADDR_W-1:1], ~written[i][0]});
		end
	endtask

	task automatic write_outside_download();
		for (int i = 0; i < 8; i++) begin
			write_byte(written[i * 8], ~rom_model[written[i * 8]]);
		end
		for (int i = 0; i < 8; i++) begin
			read_check(written[i * 8]);
		end
	endtask

	task automatic pulse_reset_sources();
		for (int src = 0; src < 2; src++) begin
			@(posedge clk_48);
			status_reset <= (src == 0);
			button_reset <= (src == 1);
			@(posedge clk_48);
			status_reset <= 1'b0;
			button_reset <= 1'b0;
			@(negedge clk_48);
			check_value("core_reset", core_reset, 1);
			check_value("rom_loaded", rom_loaded, 1);
			@(posedge clk_48);
			@(negedge clk_48);
			check_value("core_reset", core_reset, 0);
		end
	endtask

	task automatic expand_random_pixels();
		raw_pixel_t p;
		stim_q.delete();
		exp_q.delete();
		chk_q.delete();
		for (int i = 0; i < N_PIXELS; i++) begin
			p = raw_pixel_t'(take_bits($bits(raw_pixel_t)));
			stim_q.push_back(p);
			exp_q.push_back(expect_pixel(p, SCAN_OFF, 1'b0));
			chk_q.push_back(1'b1);
		end
		stream_video(SCAN_OFF);
	endtask

	task automatic dim_scanline_frames();
		raw_pixel_t p;
		logic       odd;
		logic       hs_prev;
		for (int lv = 0; lv < 4; lv++) begin
			stim_q.delete();
			exp_q.delete();
			chk_q.delete();
			odd = 1'bx;
			hs_prev = 1'b0;
			for (int i = 0; i < 2 + N_LINES * LINE_LEN; i++) begin
				p = '0;
				p.r = 3'(take_bits(3));
				p.g = 3'(take_bits(3));
				p.b = 2'(take_bits(2));
				p.vs = (i < 2);
				p.hs = (i >= 2) && ((i - 2) % LINE_LEN < 2);
				stim_q.push_back(p);
				exp_q.push_back(expect_pixel(p, scan_level_t'(lv), odd));
				chk_q.push_back(i > 0);
				// Parity clears during vsync and flips on each rising hsync.
				if (p.vs) begin
					odd = 1'b0;
				end else if (p.hs && !hs_prev) begin
					odd = ~odd;
				end
				hs_prev = p.hs;
			end
			stream_video(scan_level_t'(lv));
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s: %0d errors", name, errors - errs_before);
	endtask

	initial begin
		int errs_before;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		status_reset = 1'b0;
		button_reset = 1'b0;
		rom_addr = '0;
		pixel_in = '0;
		scanlines = SCAN_OFF;
		repeat (2) @(posedge clk_48);
		reset <= 1'b0;

		errs_before = errors;
		gate_reset_on_download();
		report_test("reset gating", errs_before);
		errs_before = errors;
		load_and_read_back();
		report_test("download and read back", errs_before);
		errs_before = errors;
		write_outside_download();
		report_test("writes outside a download", errs_before);
		errs_before = errors;
		pulse_reset_sources();
		report_test("reset sources", errs_before);
		errs_before = errors;
		expand_random_pixels();
		report_test("blanking and expansion", errs_before);
		errs_before = errors;
		dim_scanline_frames();
		report_test("scanlines", errs_before);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles.", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== hw/arcade_shell.sv ====
`timescale 1ns/1ps

module arcade_shell (
	input  logic                          clk_48,
	input  logic                          reset,

	// Loader.
	input  logic                          ioctl_download,
	input  logic                          ioctl_wr,
	input  logic [dl_pkg::ROM_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                    ioctl_dout,

	// Reset requests.
	input  logic                          status_reset,
	input  logic                          button_reset,

	// CPU side of the ROM.
	input  logic [dl_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic [7:0]                    rom_data,

	// Video.
	input  video_pkg::raw_pixel_t         pixel_in,
	input  video_pkg::scan_level_t        scanlines,
	output video_pkg::out_pixel_t         pixel_out,

	output logic                          core_reset,
	output logic                          rom_loaded
);
	import dl_pkg::*;
	import video_pkg::*;

	dl_write_t  wr_cmd;
	out_pixel_t expanded;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Download pipeline.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	download_sequencer i_download_sequencer (
		.clk_48         (clk_48),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.status_reset   (status_reset),
		.button_reset   (button_reset),
		.wr_cmd         (wr_cmd),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

	rom_store i_rom_store (
		.clk_48   (clk_48),
		.wr_cmd   (wr_cmd),
		.rom_addr (rom_addr),
		.rom_data (rom_data)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Video pipeline.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	color_expand i_color_expand (
		.clk_48   (clk_48),
		.reset    (reset),
		.pixel_in (pixel_in),
		.expanded (expanded)
	);

	scanline_dim i_scanline_dim (
		.clk_48    (clk_48),
		.reset     (reset),
		.expanded  (expanded),
		.scanlines (scanlines),
		.pixel_out (pixel_out)
	);

endmodule

// ==== hw/scanline_dim.sv ====
`timescale 1ns/1ps

module scanline_dim (
	input  logic                   clk_48,
	input  logic                   reset,
	input  video_pkg::out_pixel_t  expanded,
	input  video_pkg::scan_level_t scanlines,
	output video_pkg::out_pixel_t  pixel_out
);
	import video_pkg::*;

	logic hs_prev;
	logic odd_line;
	logic dim_en;

	// Truncating scale of one channel.
	function automatic logic [OUT_W-1:0] scale(
		input logic [OUT_W-1:0] c,
		input scan_level_t      level
	);
		logic [OUT_W-1:0] res;
		case (level)
			SCAN_DIM25: res = c - (c >> 2);
			SCAN_DIM50: res = c >> 1;
			SCAN_DIM75: res = c >> 2;
			default:    res = c;
		endcase
		return res;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Line parity.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Vsync clears the parity and each rising hsync flips it.
	always_ff @(posedge clk_48) begin
		if (reset) begin
			hs_prev <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hs_prev <= expanded.hs;
			if (expanded.vs) begin
				odd_line <= 1'b0;
			end else if (expanded.hs & ~hs_prev) begin
				odd_line <= ~odd_line;
			end
		end
	end

	assign dim_en = odd_line && (scanlines != SCAN_OFF);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_48) begin
		if (reset) begin
			pixel_out <= '0;
		end else begin
			pixel_out.r <= dim_en ? scale(expanded.r, scanlines) : expanded.r;
			pixel_out.g <= dim_en ? scale(expanded.g, scanlines) : expanded.g;
			pixel_out.b <= dim_en ? scale(expanded.b, scanlines) : expanded.b;
			pixel_out.hs <= expanded.hs;
			pixel_out.vs <= expanded.vs;
		end
	end

endmodule

// ==== hw/color_expand.sv ====
`timescale 1ns/1ps

module color_expand (
	input  logic                   clk_48,
	input  logic                   reset,
	input  video_pkg::raw_pixel_t  pixel_in,
	output video_pkg::out_pixel_t  expanded
);
	import video_pkg::*;

	logic       blank;
	logic [2:0] r3;
	logic [2:0] g3;
	logic [2:0] b3;

	// Repeat the 3-bit pattern so full scale stays full scale.
	function automatic logic [OUT_W-1:0] widen(input logic [2:0] c);
		return {c, c};
	endfunction

	assign blank = pixel_in.hblank | pixel_in.vblank;

	assign r3 = blank ? 3'd0 : pixel_in.r;
	assign g3 = blank ? 3'd0 : pixel_in.g;
	// Blue gets its top bit repeated to reach 3 bits first.
	assign b3 = blank ? 3'd0 : {pixel_in.b[RAW_B_W-1], pixel_in.b};

	always_ff @(posedge clk_48) begin
		if (reset) begin
			expanded <= '0;
		end else begin
			expanded.r <= widen(r3);
			expanded.g <= widen(g3);
			expanded.b <= widen(b3);
			expanded.hs <= pixel_in.hs;
			expanded.vs <= pixel_in.vs;
		end
	end

endmodule

// ==== hw/rom_store.sv ====
`timescale 1ns/1ps

module rom_store (
	input  logic                          clk_48,
	input  dl_pkg::dl_write_t             wr_cmd,
	input  logic [dl_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic [7:0]                    rom_data
);
	import dl_pkg::*;

	logic [ROM_DATA_W-1:0] mem [ROM_WORDS];
	logic [ROM_DATA_W-1:0] word_q;
	logic                  odd_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Byte-lane write port.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_48) begin
		if (wr_cmd.valid) begin
			if (wr_cmd.be[0]) begin
				mem[wr_cmd.addr][7:0] <= wr_cmd.data[7:0];
			end
			if (wr_cmd.be[1]) begin
				mem[wr_cmd.addr][15:8] <= wr_cmd.data[15:8];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read port.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The read takes one cycle and picks the lane by the registered address bit.
	always_ff @(posedge clk_48) begin
		word_q <= mem[rom_addr[ROM_ADDR_W-1:1]];
		odd_q <= rom_addr[0];
	end

	assign rom_data = odd_q ? word_q[15:8] : word_q[7:0];

endmodule

// ==== hw/download_sequencer.sv ====
`timescale 1ns/1ps

module download_sequencer (
	input  logic                       clk_48,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  logic [dl_pkg::ROM_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                 ioctl_dout,
	input  logic                       status_reset,
	input  logic                       button_reset,
	output dl_pkg::dl_write_t          wr_cmd,
	output logic                       rom_loaded,
	output logic                       core_reset
);
	import dl_pkg::*;

	logic                  wr_s;
	logic                  wr_prev;
	logic                  dl_d;
	logic [ROM_ADDR_W-1:0] addr_s;
	logic [7:0]            dout_s;
	logic                  wr_rise;
	logic                  loaded = 1'b0;

	// A write counts on a rising strobe while the download level is up.
	assign wr_rise = wr_s & ~wr_prev & dl_d;

	always_ff @(posedge clk_48) begin
		if (reset) begin
			wr_s <= 1'b0;
			wr_prev <= 1'b0;
			dl_d <= 1'b0;
		end else begin
			wr_s <= ioctl_wr;
			wr_prev <= wr_s;
			dl_d <= ioctl_download;
		end
	end

	// Address and data are sampled with the strobe.
	always_ff @(posedge clk_48) begin
		addr_s <= ioctl_addr;
		dout_s <= ioctl_dout;
	end

	always_ff @(posedge clk_48) begin
		if (reset) begin
			wr_cmd.valid <= 1'b0;
		end else begin
			wr_cmd.valid <= wr_rise;
		end
		wr_cmd.addr <= addr_s[ROM_ADDR_W-1:1];
		wr_cmd.data <= {dout_s, dout_s};
		wr_cmd.be <= {addr_s[0], ~addr_s[0]};
	end

	// The flag is set when the first download ends and is never cleared.
	always_ff @(posedge clk_48) begin
		if (dl_d & ~ioctl_download) begin
			loaded <= 1'b1;
		end
	end

	assign rom_loaded = loaded;

	always_ff @(posedge clk_48) begin
		if (reset) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= status_reset | button_reset | ~loaded;
		end
	end

endmodule

// ==== hw/video_pkg.sv ====
package video_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channel widths.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int RAW_R_W = 3;
	localparam int RAW_G_W = 3;
	localparam int RAW_B_W = 2;
	localparam int OUT_W = 6;

	// Scanline darkening applied to odd lines.
	typedef enum logic [1:0] {
		SCAN_OFF   = 2'd0,
		SCAN_DIM25 = 2'd1,
		SCAN_DIM50 = 2'd2,
		SCAN_DIM75 = 2'd3
	} scan_level_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Video beats.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [RAW_R_W-1:0] r;
		logic [RAW_G_W-1:0] g;
		logic [RAW_B_W-1:0] b;
		logic               hblank;
		logic               vblank;
		logic               hs;
		logic               vs;
	} raw_pixel_t;

	typedef struct packed {
		logic [OUT_W-1:0] r;
		logic [OUT_W-1:0] g;
		logic [OUT_W-1:0] b;
		logic             hs;
		logic             vs;
	} out_pixel_t;

endpackage

// ==== hw/dl_pkg.sv ====
package dl_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ROM geometry.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The loader addresses bytes; the store holds 16-bit words.
	localparam int ROM_ADDR_W = 15;
	localparam int ROM_WORD_ADDR_W = ROM_ADDR_W - 1;
	localparam int ROM_WORDS = 16384;

	localparam int ROM_DATA_W = 16;
	localparam int ROM_BE_W = ROM_DATA_W / 8;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write command.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The byte is copied into both lanes and be picks the lane that is written.
	// be[1] is the odd byte, be[0] the even one.
	typedef struct packed {
		logic [ROM_WORD_ADDR_W-1:0] addr;
		logic [ROM_DATA_W-1:0]      data;
		logic [ROM_BE_W-1:0]        be;
		logic                       valid;
	} dl_write_t;

endpackage
